// ==== ac97_link.f ====
+incdir+src
src/ac97_frame_pkg.sv
src/ac97_codec_pkg.sv
src/ac97_slot_if.sv
src/ac97_frame_serializer.sv
src/ac97_frame_receiver.sv
src/ac97_codec_init.sv
src/ac97_square_tone.sv
src/ac97_top.sv
tb/ac97_assertions.sv
tb/ac97_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AC'97 link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module ac97_tb -f ac97_link.f -o ac97_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/ac97_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tb/ac97_tb.sv ====
////////////////////////////////////////////////////////////
// AC'97 controller testbench: clock, reset, codec model,
// reference frames, compare process and report
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ac97_macros.svh"

module ac97_tb
   import ac97_frame_pkg::*;
   import ac97_codec_pkg::*;
();

   localparam int NUM_FRAMES  = 32;
   localparam int CMD_FRAMES  = 21;  // Frames 0 to 20 checked for commands
   localparam int LAST_BIT    = `AC97_FRAME_BITS - 1;
   localparam int RAND_BITS   = `AC97_TAG_BITS + 2 * `AC97_SLOT_BITS;
   localparam int PAD_BITS    = `AC97_FRAME_BITS - `AC97_TAG_BITS - 4 * `AC97_SLOT_BITS;
   localparam int TIMEOUT_CYC = 40 * `AC97_FRAME_BITS + 64;

   logic        ac97_bitclk;
   logic        rst;
   logic        ac97_sdata_in;
   logic        ac97_sdata_out;
   logic        ac97_sync;
   logic        ac97_reset_b;
   logic        codec_ready;
   logic        status_valid;
   logic [6:0]  status_addr;
   logic [15:0] status_data;

   logic [31:0] lfsr;
   frame_t      in_frame;      // Frame the codec model is sending
   frame_t      in_sent[$];    // Sent frames awaiting the status check
   frame_t      out_frame;
   int          bit_pos;       // Model of the link bit counter
   logic        new_in_frame;
   logic        status_due;
   int          out_frames;
   int          cycle_cnt;
   int          checks[1:5];
   int          errors[1:5];
   string       test_names[1:5];

   initial ac97_bitclk = 1'b0;
   always #2 ac97_bitclk = ~ac97_bitclk;

   ac97_top i_dut (
      .ac97_bitclk    (ac97_bitclk),
      .rst            (rst),
      .ac97_sdata_in  (ac97_sdata_in),
      .ac97_sdata_out (ac97_sdata_out),
      .ac97_sync      (ac97_sync),
      .ac97_reset_b   (ac97_reset_b),
      .codec_ready    (codec_ready),
      .status_valid   (status_valid),
      .status_addr    (status_addr),
      .status_data    (status_data)
   );

   bind ac97_top ac97_assertions i_assertions (
      .ac97_bitclk  (ac97_bitclk),
      .rst          (rst),
      .ac97_sync    (ac97_sync),
      .ac97_reset_b (ac97_reset_b),
      .bit_idx      (bit_idx),
      .codec_ready  (codec_ready),
      .status_valid (status_valid),
      .status_addr  (status_addr),
      .status_data  (status_data)
   );

   // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_random_bit(output logic b);
      lfsr = lfsr_next(lfsr);
      b    = lfsr[0];
   endtask

   // Tag, slot 1 and slot 2 random, the rest idle
   task automatic make_input_frame(output frame_t f);
      logic b;
      f = '0;
      for (int i = 0; i < RAND_BITS; i++) begin
         take_random_bit(b);
         f[i] = b;
      end
   endtask

   // Output frame n: command entry n, tone word from bit 3 of n
   function automatic frame_t expected_out_frame(input int n);
      int          entry;
      logic        rd;
      reg_addr_t   addr;
      logic [15:0] data;
      slot_t       tone;
      entry = (n < 3) ? n : 3 + (n - 3) % 3;
      rd    = (entry >= 3);
      case (entry)
         0:       addr = REG_RESET;
         1:       addr = REG_MASTER_VOL;
         2:       addr = REG_PCM_VOL;
         3:       addr = REG_POWER;
         4:       addr = REG_VID0;
         default: addr = REG_VID1;
      endcase
      data = (entry == 1) ? `AC97_MASTER_VOL :
             (entry == 2) ? `AC97_PCM_VOL : 16'h0000;
      tone = n[3] ? `AC97_TONE_LOW : `AC97_TONE_HIGH;
      return {1'b1, 4'b1111, 8'b0, 3'b0,  // Frame bit, slots 1 to 4 valid
              rd, addr, 12'b0,
              data, 4'b0,
              tone, tone,
              {PAD_BITS{1'b0}}};
   endfunction

   // {ready, valid, addr, data}; address at bits 17..23, data at 36..51
   function automatic logic [24:0] expected_status(input frame_t f);
      return {f[0], f[1] & f[2], f[17:23], f[36:51]};
   endfunction

   task automatic check_value(input int test, input string what,
                              input logic [255:0] got, input logic [255:0] exp);
      checks[test]++;
      if (got !== exp) begin
         errors[test]++;
         $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input int test);
      $display("Test %0d %s: %0d checks, %0d errors",
               test, test_names[test], checks[test], errors[test]);
   endtask

   task automatic check_out_frame(input int n, input frame_t got);
      frame_t exp;
      int     test;
      exp  = expected_out_frame(n);
      test = (n < 6) ? 1 : 2;
      if (n < CMD_FRAMES) begin
         check_value(test, $sformatf("frame %0d tag", n), got[0:15], exp[0:15]);
         check_value(test, $sformatf("frame %0d slot 1", n), got[16:35], exp[16:35]);
         check_value(test, $sformatf("frame %0d slot 2", n), got[36:55], exp[36:55]);
         check_value(test, $sformatf("frame %0d slots 5-12", n), got[96:255], exp[96:255]);
      end
      check_value(3, $sformatf("frame %0d slots 3-4", n), got[56:95], exp[56:95]);
      if (n == 5 || n == CMD_FRAMES - 1)
         report_test(test);
      if (n == NUM_FRAMES - 1)
         report_test(3);
   endtask

   // Codec model drives the bit the link counter is on
   always @(negedge ac97_bitclk) begin
      if (new_in_frame) begin
         make_input_frame(in_frame);
         in_sent.push_back(in_frame);
         new_in_frame = 1'b0;
      end
      ac97_sdata_in <= in_frame[bit_pos];
   end

   // Capture and compare, values taken before this edge's updates
   always @(posedge ac97_bitclk) begin
      logic [24:0] got_status;
      if (!rst) begin
         out_frame[bit_pos] = ac97_sdata_out;
         check_value(5, $sformatf("sync at bit %0d", bit_pos), ac97_sync,
                     (bit_pos == LAST_BIT) || (bit_pos < `AC97_SYNC_BITS - 1));
         if (out_frames != 0 || bit_pos != 0)
            check_value(5, "reset_b", ac97_reset_b, 1'b1);  // Released at first edge
         if (status_due) begin
            got_status = {codec_ready, status_valid, status_addr, status_data};
            check_value(4, $sformatf("status after input frame %0d", out_frames - 1),
                        got_status, expected_status(in_sent.pop_front()));
            status_due = 1'b0;
         end
         if (bit_pos == LAST_BIT) begin
            check_out_frame(out_frames, out_frame);
            out_frames++;
            bit_pos      = 0;
            new_in_frame = 1'b1;
            status_due   = 1'b1;  // Receiver latched at this edge
         end else begin
            bit_pos++;
         end
      end
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYC) begin
         @(posedge ac97_bitclk);
         cycle_cnt++;
      end
      $display("Timeout: only %0d of %0d output frames seen after %0d cycles",
               out_frames, NUM_FRAMES, cycle_cnt);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      int total_checks;
      int total_errors;
      rst           = 1'b1;
      ac97_sdata_in = 1'b0;
      lfsr          = 32'hc207;
      bit_pos       = 0;
      new_in_frame  = 1'b1;
      status_due    = 1'b0;
      out_frames    = 0;
      test_names[1] = "command writes, frames 0-5";
      test_names[2] = "command polling, frames 6-20";
      test_names[3] = "tone slots, frames 0-31";
      test_names[4] = "status latch";
      test_names[5] = "sync and codec reset";
      for (int t = 1; t <= 5; t++) begin
         checks[t] = 0;
         errors[t] = 0;
      end
      repeat (8) @(negedge ac97_bitclk);
      rst = 1'b0;
      wait (out_frames == NUM_FRAMES);
      repeat (2) @(negedge ac97_bitclk);  // Status of the last input frame
      report_test(4);
      report_test(5);
      total_checks = 0;
      total_errors = 0;
      for (int t = 1; t <= 5; t++) begin
         total_checks += checks[t];
         total_errors += errors[t];
      end
      $display("Total: %0d checks, %0d errors", total_checks, total_errors);
      if (total_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== tb/ac97_assertions.sv ====
////////////////////////////////////////////////////////////
// Concurrent checks on sync timing, codec reset and the
// status outputs before the first frame is latched
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ac97_assertions (
   input logic        ac97_bitclk,
   input logic        rst,
   input logic        ac97_sync,
   input logic        ac97_reset_b,
   input logic [7:0]  bit_idx,
   input logic        codec_ready,
   input logic        status_valid,
   input logic [6:0]  status_addr,
   input logic [15:0] status_data
);

   logic [8:0] run_len;    // Samples in the current sync level
   logic       prev_sync;
   logic       seen_rise;  // First high run after reset is short
   logic       latched;

   always_ff @(posedge ac97_bitclk or posedge rst) begin
      if (rst) begin
         run_len   <= 9'd1;
         prev_sync <= 1'b1;
         seen_rise <= 1'b0;
         latched   <= 1'b0;
      end else begin
         prev_sync <= ac97_sync;
         run_len   <= (ac97_sync == prev_sync) ? run_len + 9'd1 : 9'd1;
         if (ac97_sync && !prev_sync)
            seen_rise <= 1'b1;
         if (bit_idx == 8'd255)
            latched <= 1'b1;  // Receiver latches at this edge
      end
   end

   sync_high_run: assert property (@(posedge ac97_bitclk) disable iff (rst)
      (seen_rise && prev_sync && !ac97_sync) |-> (run_len == 9'd16))
      else $error("sync was not high for 16 cycles in a row");

   sync_low_run: assert property (@(posedge ac97_bitclk) disable iff (rst)
      (!prev_sync && ac97_sync) |-> (run_len == 9'd240))
      else $error("sync was not low for 240 cycles in a row");

   reset_b_low: assert property (@(posedge ac97_bitclk)
      (rst && $past(rst)) |-> !ac97_reset_b)
      else $error("codec reset released while rst is high");

   status_idle: assert property (@(posedge ac97_bitclk) disable iff (rst)
      !latched |-> (!codec_ready && !status_valid &&
                    status_addr == 7'h00 && status_data == 16'h0000))
      else $error("status outputs nonzero before the first input frame");

endmodule

// ==== src/ac97_top.sv ====
////////////////////////////////////////////////////////////
// AC'97 controller top: link, init sequencer, test tone
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ac97_top (
   input  logic        ac97_bitclk,
   input  logic        rst,
   input  logic        ac97_sdata_in,
   output logic        ac97_sdata_out,
   output logic        ac97_sync,
   output logic        ac97_reset_b,
   output logic        codec_ready,
   output logic        status_valid,
   output logic [6:0]  status_addr,
   output logic [15:0] status_data
);

   logic [7:0] bit_idx;  // Shared frame position

   ac97_slot_if slots ();

   ac97_frame_serializer i_serializer (
      .ac97_bitclk    (ac97_bitclk),
      .rst            (rst),
      .ac97_sdata_out (ac97_sdata_out),
      .ac97_sync      (ac97_sync),
      .ac97_reset_b   (ac97_reset_b),
      .bit_idx        (bit_idx),
      .slots          (slots)
   );

   ac97_frame_receiver i_receiver (
      .ac97_bitclk    (ac97_bitclk),
      .rst            (rst),
      .ac97_sdata_in  (ac97_sdata_in),
      .bit_idx        (bit_idx),
      .codec_ready    (codec_ready),
      .status_valid   (status_valid),
      .status_addr    (status_addr),
      .status_data    (status_data)
   );

   ac97_codec_init i_codec_init (
      .ac97_bitclk    (ac97_bitclk),
      .rst            (rst),
      .slots          (slots)
   );

   ac97_square_tone i_square_tone (
      .ac97_bitclk    (ac97_bitclk),
      .rst            (rst),
      .slots          (slots)
   );

endmodule

// ==== src/ac97_square_tone.sv ====
////////////////////////////////////////////////////////////
// Square-wave PCM source for slots 3 and 4
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ac97_macros.svh"

module ac97_square_tone
   import ac97_frame_pkg::*;
(
   input  logic     ac97_bitclk,
   input  logic     rst,
   ac97_slot_if.pcm slots
);

   // Top counter bit picks the half period
   localparam int HALF_BIT = $clog2(`AC97_TONE_HALF_FRAMES);

   logic [HALF_BIT:0] frame_cnt;
   slot_t             tone_word;

   always_ff @(posedge ac97_bitclk or posedge rst) begin
      if (rst)
         frame_cnt <= '0;
      else if (slots.frame_strobe)
         frame_cnt <= frame_cnt + 1'b1;
   end

   assign tone_word = frame_cnt[HALF_BIT] ? `AC97_TONE_LOW : `AC97_TONE_HIGH;

   assign slots.pcm_left  = tone_word;  // Same word on both channels
   assign slots.pcm_right = tone_word;
   assign slots.pcm_valid = 1'b1;

endmodule

// ==== src/ac97_codec_init.sv ====
////////////////////////////////////////////////////////////
// Codec command sequencer for slots 1 and 2
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ac97_macros.svh"

module ac97_codec_init
   import ac97_codec_pkg::*;
(
   input  logic     ac97_bitclk,
   input  logic     rst,
   ac97_slot_if.cmd slots
);

   init_state_t state;
   init_state_t state_next;
   cmd_slot_t   cmd;
   logic [15:0] wr_data;

   // Advances as the last bit of a frame goes out
   always_ff @(posedge ac97_bitclk or posedge rst) begin
      if (rst)
         state <= INIT_RESET;
      else if (slots.frame_strobe)
         state <= state_next;
   end

   always_comb begin
      cmd        = '0;  // Write, reserved bits zero
      wr_data    = 16'h0000;
      state_next = state;
      case (state)
         INIT_RESET: begin
            cmd.addr   = REG_RESET;
            state_next = INIT_MASTER_VOL;
         end
         INIT_MASTER_VOL: begin
            cmd.addr   = REG_MASTER_VOL;
            wr_data    = `AC97_MASTER_VOL;
            state_next = INIT_PCM_VOL;
         end
         INIT_PCM_VOL: begin
            cmd.addr   = REG_PCM_VOL;
            wr_data    = `AC97_PCM_VOL;
            state_next = POLL_POWER;
         end
         POLL_POWER: begin
            cmd.read   = 1'b1;
            cmd.addr   = REG_POWER;
            state_next = POLL_VID0;
         end
         POLL_VID0: begin
            cmd.read   = 1'b1;
            cmd.addr   = REG_VID0;
            state_next = POLL_VID1;
         end
         POLL_VID1: begin
            cmd.read   = 1'b1;
            cmd.addr   = REG_VID1;
            state_next = POLL_POWER;  // Keep polling
         end
         default: begin
            cmd.addr   = REG_RESET;
            state_next = INIT_RESET;
         end
      endcase
   end

   assign slots.cmd_addr   = cmd;
   assign slots.cmd_valid  = 1'b1;
   assign slots.cmd_data   = {wr_data, 4'h0};
   assign slots.data_valid = 1'b1;

endmodule

// ==== src/ac97_frame_receiver.sv ====
////////////////////////////////////////////////////////////
// AC-link input side: frame capture, tag and status latch
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ac97_macros.svh"

module ac97_frame_receiver
   import ac97_frame_pkg::*;
   import ac97_codec_pkg::*;
(
   input  logic        ac97_bitclk,
   input  logic        rst,
   input  logic        ac97_sdata_in,
   input  bit_idx_t    bit_idx,
   output logic        codec_ready,
   output logic        status_valid,
   output reg_addr_t   status_addr,
   output logic [15:0] status_data
);

   localparam bit_idx_t LAST_BIT = bit_idx_t'(`AC97_FRAME_BITS - 1);
   localparam int SLOT1_POS = `AC97_TAG_BITS;
   localparam int SLOT2_POS = `AC97_TAG_BITS + `AC97_SLOT_BITS;

   frame_t    in_frame;
   frame_t    full_frame;
   tag_t      in_tag;
   cmd_slot_t in_status;
   slot_t     in_data;

   always_ff @(posedge ac97_bitclk) begin
      in_frame[bit_idx] <= ac97_sdata_in;
   end

   // Last bit taken straight from the pin
   always_comb begin
      full_frame           = in_frame;
      full_frame[LAST_BIT] = ac97_sdata_in;
   end

   assign in_tag    = full_frame[0 +: `AC97_TAG_BITS];
   assign in_status = full_frame[SLOT1_POS +: `AC97_SLOT_BITS];
   assign in_data   = full_frame[SLOT2_POS +: `AC97_SLOT_BITS];

   always_ff @(posedge ac97_bitclk or posedge rst) begin
      if (rst) begin
         codec_ready  <= 1'b0;
         status_valid <= 1'b0;
         status_addr  <= '0;
         status_data  <= '0;
      end else if (bit_idx == LAST_BIT) begin
         codec_ready  <= in_tag.frame_ready;
         status_valid <= in_tag.slot_valid[1] & in_tag.slot_valid[2];
         status_addr  <= in_status.addr;
         status_data  <= in_data[`AC97_SLOT_BITS-1 -: 16];  // Low nibble reserved
      end
   end

endmodule

// ==== src/ac97_frame_serializer.sv ====
////////////////////////////////////////////////////////////
// AC-link output side: bit counter, sync, frame strobe,
// tag assembly, serial data and codec reset release
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ac97_macros.svh"

module ac97_frame_serializer
   import ac97_frame_pkg::*;
(
   input  logic      ac97_bitclk,
   input  logic      rst,
   output logic      ac97_sdata_out,
   output logic      ac97_sync,
   output logic      ac97_reset_b,
   output bit_idx_t  bit_idx,
   ac97_slot_if.link slots
);

   // Slots 5 to 12 carry nothing
   localparam int PAD_BITS = `AC97_FRAME_BITS - `AC97_TAG_BITS - 4 * `AC97_SLOT_BITS;
   localparam bit_idx_t LAST_BIT = bit_idx_t'(`AC97_FRAME_BITS - 1);
   localparam bit_idx_t SYNC_END = bit_idx_t'(`AC97_SYNC_BITS - 1);

   tag_t   tag;
   frame_t out_frame;

   always_ff @(posedge ac97_bitclk or posedge rst) begin
      if (rst) begin
         bit_idx      <= '0;
         ac97_reset_b <= 1'b0;
      end else begin
         bit_idx      <= bit_idx + 1'b1;  // Wraps 255 to 0
         ac97_reset_b <= 1'b1;            // Codec leaves reset on first edge
      end
   end

   always_comb begin
      tag               = '0;
      tag.frame_ready   = 1'b1;
      tag.slot_valid[1] = slots.cmd_valid;
      tag.slot_valid[2] = slots.data_valid;
      tag.slot_valid[3] = slots.pcm_valid;
      tag.slot_valid[4] = slots.pcm_valid;
   end

   // Tag MSB first, invalid slots forced to zero
   assign out_frame = {tag,
                       slots.cmd_valid  ? slots.cmd_addr  : slot_t'(0),
                       slots.data_valid ? slots.cmd_data  : slot_t'(0),
                       slots.pcm_valid  ? slots.pcm_left  : slot_t'(0),
                       slots.pcm_valid  ? slots.pcm_right : slot_t'(0),
                       {PAD_BITS{1'b0}}};

   assign ac97_sdata_out = out_frame[bit_idx];

   // Rises during the last bit, falls after the last tag bit
   assign ac97_sync = (bit_idx == LAST_BIT) || (bit_idx < SYNC_END);

   assign slots.frame_strobe = (bit_idx == LAST_BIT);

endmodule

// ==== src/ac97_slot_if.sv ====
////////////////////////////////////////////////////////////
// Outgoing slot words and frame strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface ac97_slot_if
   import ac97_frame_pkg::*;
();

   logic  frame_strobe;  // High while bit 255 is on the wire
   slot_t cmd_addr;      // Slot 1
   logic  cmd_valid;
   slot_t cmd_data;      // Slot 2
   logic  data_valid;
   slot_t pcm_left;      // Slot 3
   slot_t pcm_right;     // Slot 4
   logic  pcm_valid;

   modport link (output frame_strobe,
                 input  cmd_addr, cmd_valid, cmd_data, data_valid,
                 input  pcm_left, pcm_right, pcm_valid);

   modport cmd (input  frame_strobe,
                output cmd_addr, cmd_valid, cmd_data, data_valid);

   modport pcm (input  frame_strobe,
                output pcm_left, pcm_right, pcm_valid);

endinterface

// ==== src/ac97_codec_pkg.sv ====
////////////////////////////////////////////////////////////
// Codec register command types and init sequence states
////////////////////////////////////////////////////////////

package ac97_codec_pkg;

   typedef logic [6:0] reg_addr_t;

   // Codec registers used by the init sequence
   localparam reg_addr_t REG_RESET      = 7'h00;
   localparam reg_addr_t REG_MASTER_VOL = 7'h02;
   localparam reg_addr_t REG_PCM_VOL    = 7'h18;
   localparam reg_addr_t REG_POWER      = 7'h26;  // Power down control / status
   localparam reg_addr_t REG_VID0       = 7'h7C;
   localparam reg_addr_t REG_VID1       = 7'h7E;

   // Three writes once, then a three-entry read loop
   typedef enum logic [2:0] {
      INIT_RESET,
      INIT_MASTER_VOL,
      INIT_PCM_VOL,
      POLL_POWER,
      POLL_VID0,
      POLL_VID1
   } init_state_t;

   // Command slot 1 out, status slot 1 in
   typedef struct packed {
      logic        read;      // 1 = read, 0 = write
      reg_addr_t   addr;
      logic [11:0] reserved;
   } cmd_slot_t;

endpackage

// ==== src/ac97_frame_pkg.sv ====
////////////////////////////////////////////////////////////
// AC-link frame layout types: slot word, bit index, tag
////////////////////////////////////////////////////////////

`include "ac97_macros.svh"

package ac97_frame_pkg;

   // One 20-bit slot word, MSB sent first
   typedef logic [`AC97_SLOT_BITS-1:0] slot_t;

   // Position of the current bit in a frame
   typedef logic [7:0] bit_idx_t;

   // Whole frame, index 0 is the first bit on the wire
   typedef logic [0:`AC97_FRAME_BITS-1] frame_t;

   // Tag slot
   typedef struct packed {
      logic        frame_ready;  // Frame valid out, codec ready in
      logic [1:12] slot_valid;   // Slot 1 flag is the MSB
      logic [2:0]  zero_bits;
   } tag_t;

endpackage

// ==== src/ac97_macros.svh ====
////////////////////////////////////////////////////////////
// AC-link frame, slot, sync and tone constants
// Codec init register values
////////////////////////////////////////////////////////////

`ifndef AC97_MACROS_SVH
`define AC97_MACROS_SVH

// Frame layout
`define AC97_FRAME_BITS 256
`define AC97_SLOT_BITS 20
`define AC97_TAG_BITS 16

// Sync high from bit 255 through bit 14
`define AC97_SYNC_BITS 16

// Square tone, full period is two halves
`define AC97_TONE_HALF_FRAMES 8
`define AC97_TONE_HIGH 20'h7FFFF
`define AC97_TONE_LOW 20'h80000

// Codec init write data
`define AC97_MASTER_VOL 16'h0000  // Unmuted, full volume
`define AC97_PCM_VOL 16'h0808     // Unmuted, 0 dB gain

`endif
